/* frame_defines.svh */
`ifndef FRAME_DEFINES_SVH
`define FRAME_DEFINES_SVH

// ------------------------------
// frame geometry
// ------------------------------

// pixels per frame, kept small for short runs
`define FRAME_PIXELS 16

// pixel width, two bytes on the line
`define PIX_W 16

// ------------------------------
// pixel fifo
// ------------------------------

`define FIFO_DEPTH 8 // entries, power of two
`define FIFO_AW 3 // log2 of depth

// ------------------------------
// serial line
// ------------------------------

// SYS_CLK cycles per serial bit
`define CLK_DIV 8

`endif

/* frame_pkg.sv */
package frame_pkg;

	// frame type byte, as the host debug tool decodes it
	typedef enum logic [7:0] {
		MODE_IMAGE = 8'h01, // camera image
		MODE_CCD   = 8'h02, // linear ccd
		MODE_WAVE  = 8'h03 // waveform
	} frame_mode_e;

	// frame_ctrl sections
	typedef enum logic [1:0] {
		ST_IDLE, ST_HEAD, ST_PIXEL, ST_TAIL
	} ctrl_state_e;

	// uart_tx bit phases
	typedef enum logic [1:0] {
		TX_IDLE, TX_START, TX_DATA, TX_STOP
	} tx_state_e;

endpackage

/* pixel_fifo.sv */
`timescale 1ns/100ps
`include "frame_defines.svh"

module pixel_fifo (
	input  logic               SYS_CLK,
	input  logic               RST_N,
	// write side, pixel source
	input  logic               pix_valid,
	input  logic [`PIX_W-1:0]  pix_data,
	output logic               pix_ready,
	// read side, frame control
	output logic               rd_valid,
	output logic [`PIX_W-1:0]  rd_data,
	input  logic               rd_ready
);

	// count needs one extra bit to tell full from empty
	localparam logic [`FIFO_AW:0] DEPTH = `FIFO_DEPTH;

	logic [`PIX_W-1:0]  mem [`FIFO_DEPTH]; // storage array
	logic [`FIFO_AW-1:0] wr_ptr; // next free slot
	logic [`FIFO_AW-1:0] rd_ptr; // oldest entry
	logic [`FIFO_AW:0]   count; // occupancy
	logic                push;
	logic                pop;

	// ------------------------------
	// handshakes
	// ------------------------------
	assign pix_ready = (count != DEPTH); // room left
	assign rd_valid  = (count != '0); // something stored
	assign rd_data   = mem[rd_ptr]; // head shows without a pop

	assign push = pix_valid & pix_ready;
	assign pop  = rd_valid & rd_ready;

	// ------------------------------
	// pointers and count
	// ------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2**aw
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

	// data array
	always_ff @(posedge SYS_CLK) begin
		if (push) begin
			mem[wr_ptr] <= pix_data;
		end
	end

endmodule

/* uart_tx.sv */
`timescale 1ns/100ps
`include "frame_defines.svh"

module uart_tx (
	input  logic       SYS_CLK,
	input  logic       RST_N,
	// byte input
	input  logic       tx_valid,
	input  logic [7:0] tx_data,
	output logic       tx_ready,
	// serial line, 8N1
	output logic       uart_txd
);

	localparam int BAUD_W = $clog2(`CLK_DIV);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`CLK_DIV - 1);

	frame_pkg::tx_state_e state;
	logic [BAUD_W-1:0] baud_cnt; // cycles within one bit
	logic [2:0]        bit_idx; // data bit on the line
	logic [7:0]        shift_reg; // remaining data bits, lsb out first
	logic              bit_end; // last cycle of current bit

	assign tx_ready = (state == frame_pkg::TX_IDLE); // free only when idle
	assign bit_end  = (baud_cnt == BAUD_LAST);

	// ------------------------------
	// bit sequencer
	// ------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state    <= frame_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			uart_txd <= 1'b1; // line idles high
		end else begin
			case (state)
				frame_pkg::TX_IDLE: begin
					uart_txd <= 1'b1;
					baud_cnt <= '0;
					if (tx_valid) begin // byte accepted
						state    <= frame_pkg::TX_START;
						uart_txd <= 1'b0; // start bit
					end
				end
				frame_pkg::TX_START: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						uart_txd <= shift_reg[0]; // bit 0 first
						state    <= frame_pkg::TX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				frame_pkg::TX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (bit_idx == 3'd7) begin
							uart_txd <= 1'b1; // stop bit
							state    <= frame_pkg::TX_STOP;
						end else begin
							bit_idx  <= bit_idx + 1'b1;
							uart_txd <= shift_reg[1]; // next bit
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				frame_pkg::TX_STOP: begin
					if (bit_end) begin
						baud_cnt <= '0;
						state    <= frame_pkg::TX_IDLE; // ready after 10 bits
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= frame_pkg::TX_IDLE;
			endcase
		end
	end

	// shift register, bit 0 always holds the bit on the line
	always_ff @(posedge SYS_CLK) begin
		if (tx_ready && tx_valid) begin
			shift_reg <= tx_data;
		end else if (state == frame_pkg::TX_DATA && bit_end) begin
			shift_reg <= shift_reg >> 1;
		end
	end

endmodule

/* frame_ctrl.sv */
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_ctrl (
	input  logic                   SYS_CLK,
	input  logic                   RST_N,
	input  frame_pkg::frame_mode_e mode, // sampled at frame start
	// fifo read side
	input  logic                   rd_valid,
	input  logic [`PIX_W-1:0]      rd_data,
	output logic                   rd_ready,
	// transmitter byte port
	output logic                   tx_valid,
	output logic [7:0]             tx_data,
	input  logic                   tx_ready,
	output logic                   frame_active
);

	localparam int CNT_W = $clog2(`FRAME_PIXELS);
	localparam logic [CNT_W-1:0] PIX_LAST = CNT_W'(`FRAME_PIXELS - 1);

	// byte steps in header and trailer
	localparam logic [1:0] SEC_FIRST  = 2'd0;
	localparam logic [1:0] SEC_SECOND = 2'd1;
	// steps per pixel
	localparam logic [1:0] PX_POP   = 2'd0; // wait for data, request pop
	localparam logic [1:0] PX_LATCH = 2'd1; // pop edge, capture pixel
	localparam logic [1:0] PX_LO    = 2'd2; // low byte offered
	localparam logic [1:0] PX_HI    = 2'd3; // high byte offered

	frame_pkg::ctrl_state_e state;
	frame_pkg::frame_mode_e mode_q; // frame type held for whole frame
	logic [1:0]             step;
	logic [CNT_W-1:0]       pix_cnt; // pixel index within frame
	logic [`PIX_W-1:0]      pix_q; // current pixel, fifo may refill
	logic                   tx_fire;
	logic                   pop;

	assign tx_fire = tx_valid & tx_ready; // byte taken this edge
	assign pop     = rd_valid & rd_ready;

	// ------------------------------
	// byte select
	// ------------------------------
	always_comb begin
		case (state)
			frame_pkg::ST_HEAD:  tx_data = (step == SEC_FIRST) ? mode_q : ~mode_q;
			frame_pkg::ST_PIXEL: tx_data = (step == PX_HI) ? pix_q[`PIX_W-1:8] : pix_q[7:0];
			frame_pkg::ST_TAIL:  tx_data = (step == SEC_FIRST) ? ~mode_q : mode_q;
			default:             tx_data = 8'hff; // idle filler, never offered
		endcase
	end

	// ------------------------------
	// frame sequencer
	// ------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state        <= frame_pkg::ST_IDLE;
			step         <= SEC_FIRST;
			pix_cnt      <= '0;
			tx_valid     <= 1'b0;
			rd_ready     <= 1'b0;
			frame_active <= 1'b0;
		end else begin
			case (state)
				frame_pkg::ST_IDLE: begin
					if (rd_valid) begin // pending pixel opens a frame
						frame_active <= 1'b1;
						tx_valid     <= 1'b1; // mode byte right away
						step         <= SEC_FIRST;
						state        <= frame_pkg::ST_HEAD;
					end
				end
				frame_pkg::ST_HEAD: begin
					if (tx_fire) begin
						if (step == SEC_FIRST) begin
							step <= SEC_SECOND; // complement next
						end else begin
							tx_valid <= 1'b0;
							pix_cnt  <= '0;
							step     <= PX_POP;
							state    <= frame_pkg::ST_PIXEL;
						end
					end
				end
				frame_pkg::ST_PIXEL: begin
					case (step)
						PX_POP: begin
							if (rd_valid) begin // stalls here if source runs dry
								rd_ready <= 1'b1;
								step     <= PX_LATCH;
							end
						end
						PX_LATCH: begin
							if (pop) begin
								rd_ready <= 1'b0; // single cycle pulse
								tx_valid <= 1'b1;
								step     <= PX_LO;
							end
						end
						PX_LO: begin
							if (tx_fire) begin
								step <= PX_HI;
							end
						end
						default: begin // PX_HI
							if (tx_fire) begin
								if (pix_cnt == PIX_LAST) begin
									step  <= SEC_FIRST; // trailer follows directly
									state <= frame_pkg::ST_TAIL;
								end else begin
									tx_valid <= 1'b0;
									pix_cnt  <= pix_cnt + 1'b1;
									step     <= PX_POP;
								end
							end
						end
					endcase
				end
				frame_pkg::ST_TAIL: begin
					if (tx_fire) begin
						if (step == SEC_FIRST) begin
							step <= SEC_SECOND;
						end else begin
							tx_valid     <= 1'b0;
							frame_active <= 1'b0; // last byte taken
							step         <= SEC_FIRST;
							state        <= frame_pkg::ST_IDLE;
						end
					end
				end
				default: state <= frame_pkg::ST_IDLE;
			endcase
		end
	end

	// payload capture
	always_ff @(posedge SYS_CLK) begin
		if (state == frame_pkg::ST_IDLE && rd_valid) begin
			mode_q <= mode; // later mode changes wait for next frame
		end
		if (state == frame_pkg::ST_PIXEL && step == PX_LATCH && pop) begin
			pix_q <= rd_data;
		end
	end

endmodule

/* frame_uart_top.sv */
`timescale 1ns/100ps
`include "frame_defines.svh"

module frame_uart_top (
	input  logic                   SYS_CLK,
	input  logic                   RST_N,
	// pixel stream in
	input  logic                   pix_valid,
	input  logic [`PIX_W-1:0]      pix_data,
	output logic                   pix_ready,
	input  frame_pkg::frame_mode_e mode,
	// host side
	output logic                   uart_txd,
	output logic                   frame_active
);

	// ------------------------------
	// fifo to control
	// ------------------------------
	logic              rd_valid;
	logic              rd_ready;
	logic [`PIX_W-1:0] rd_data;

	// control to transmitter
	logic              tx_valid;
	logic              tx_ready;
	logic [7:0]        tx_data;

	pixel_fifo i_fifo (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pix_ready (pix_ready),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.rd_ready  (rd_ready)
	);

	frame_ctrl i_ctrl (
		.SYS_CLK      (SYS_CLK),
		.RST_N        (RST_N),
		.mode         (mode),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.rd_ready     (rd_ready),
		.tx_valid     (tx_valid),
		.tx_data      (tx_data),
		.tx_ready     (tx_ready),
		.frame_active (frame_active)
	);

	uart_tx i_tx (
		.SYS_CLK  (SYS_CLK),
		.RST_N    (RST_N),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.tx_ready (tx_ready),
		.uart_txd (uart_txd) // idles high
	);

endmodule

/* clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
	output logic SYS_CLK
);

	localparam int HALF_NS = 50; // 100 ns period

	initial begin
		SYS_CLK = 1'b0;
		forever #(HALF_NS) SYS_CLK = ~SYS_CLK;
	end

endmodule

/* frame_asserts.sv */
`timescale 1ns/100ps
`include "frame_defines.svh"

// watches the frame_ctrl to uart_tx byte port and the serial line
module frame_asserts (
	input logic       SYS_CLK,
	input logic       RST_N,
	input logic       pix_valid,
	input logic       pix_ready,
	input logic       frame_active,
	input logic       tx_valid,
	input logic       tx_ready,
	input logic [7:0] tx_data,
	input logic       uart_txd
);

	localparam int FRAME_BYTES = 4 + 2 * `FRAME_PIXELS; // header, pixels, trailer

	int   fail_cnt = 0; // read by the testbench at the end
	logic seen_pix; // first pixel offered
	logic fire;
	logic [7:0] byte_cnt; // bytes taken so far in this frame
	logic       last_byte; // byte taken now closes the frame

	assign fire      = tx_valid & tx_ready; // byte enters uart_tx
	assign last_byte = (byte_cnt == 8'(FRAME_BYTES - 1));

	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			seen_pix <= 1'b0;
		end else if (pix_valid) begin
			seen_pix <= 1'b1;
		end
	end

	// frame position, wraps after the trailer
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			byte_cnt <= '0;
		end else if (fire) begin
			byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
		end
	end

	// ------------------------------
	// idle state and line framing
	// ------------------------------
	a_idle: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		!seen_pix |-> (uart_txd && pix_ready && !frame_active))
	else begin
		$error("line, pix_ready or frame_active not idle before first pixel");
		fail_cnt++;
	end

	// start bit low over its first and last cycle
	a_start: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		fire |-> ##1 !uart_txd ##(`CLK_DIV - 1) !uart_txd)
	else begin
		$error("start bit not low for a full bit time");
		fail_cnt++;
	end

	a_stop: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		fire |-> ##(9 * `CLK_DIV + 1) uart_txd ##(`CLK_DIV - 1) uart_txd)
	else begin
		$error("stop bit not high for a full bit time");
		fail_cnt++;
	end

	// offered byte held until taken
	a_hold: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		(tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
	else begin
		$error("tx_data or tx_valid changed while waiting for tx_ready");
		fail_cnt++;
	end

	// ------------------------------
	// frame_active window
	// ------------------------------
	a_frame_on: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		(fire && !last_byte) |=> frame_active)
	else begin
		$error("frame_active dropped before the last trailer byte");
		fail_cnt++;
	end

	a_frame_end: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		(fire && last_byte) |=> !frame_active) // falls once trailer is taken
	else begin
		$error("frame_active still high after the last trailer byte");
		fail_cnt++;
	end

endmodule

bind frame_uart_top frame_asserts i_chk (.*);

/* tb_frame_uart.sv */
`timescale 1ns/100ps
`include "frame_defines.svh"

module tb_frame_uart;

	localparam int N_FRAMES     = 3;
	localparam int FRAME_BYTES  = 4 + 2 * `FRAME_PIXELS; // header, pixels, trailer
	localparam int FRAME_CYCLES = FRAME_BYTES * 10 * `CLK_DIV;
	localparam int BIT_NS       = `CLK_DIV * 100; // one serial bit

	logic                   SYS_CLK;
	logic                   RST_N;
	logic                   pix_valid;
	logic [`PIX_W-1:0]      pix_data;
	logic                   pix_ready;
	frame_pkg::frame_mode_e mode;
	logic                   uart_txd;
	logic                   frame_active;

	logic [31:0] lfsr = 32'ha96dcbdb;
	logic [7:0]  exp_q[$]; // bytes the host should see, in order
	int          byte_errs = 0;
	int          misc_errs = 0;
	int          rx_cnt = 0;

	clk_gen i_clk (.SYS_CLK(SYS_CLK));

	frame_uart_top i_dut (
		.SYS_CLK      (SYS_CLK),
		.RST_N        (RST_N),
		.pix_valid    (pix_valid),
		.pix_data     (pix_data),
		.pix_ready    (pix_ready),
		.mode         (mode),
		.uart_txd     (uart_txd),
		.frame_active (frame_active)
	);

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v    = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// starts at a rising edge, returns on the accept edge
	task automatic send_pixel(input logic [`PIX_W-1:0] px);
		pix_valid <= 1'b1;
		pix_data  <= px;
		@(negedge SYS_CLK);
		while (!pix_ready) @(negedge SYS_CLK); // fifo full, hold pixel
		@(posedge SYS_CLK);
		exp_q.push_back(px[7:0]); // low byte first
		exp_q.push_back(px[15:8]);
	endtask

	task automatic check_byte(input logic [7:0] got);
		logic [7:0] want;
		rx_cnt++;
		if (exp_q.size() == 0) begin
			$display("unexpected byte 0x%02h on uart_txd with nothing left to send", got);
			misc_errs++;
		end else begin
			want = exp_q.pop_front();
			assert (got == want) else begin
				$display("** Error uart byte uart_txd: expected 0x%02h, got 0x%02h", want, got);
				byte_errs++;
			end
		end
	endtask

	// ------------------------------
	// stimulus and closing report
	// ------------------------------
	initial begin : stimulus
		frame_pkg::frame_mode_e modes [N_FRAMES];
		int gap;
		modes     = '{frame_pkg::MODE_IMAGE, frame_pkg::MODE_CCD, frame_pkg::MODE_WAVE};
		RST_N     = 1'b0;
		pix_valid = 1'b0;
		pix_data  = '0;
		mode      = frame_pkg::MODE_IMAGE;
		repeat (2) @(posedge SYS_CLK);
		RST_N <= 1'b1;
		repeat (4) @(posedge SYS_CLK); // idle line before first pixel
		for (int f = 0; f < N_FRAMES; f++) begin
			mode <= modes[f]; // latched at this frame's start
			exp_q.push_back(modes[f]);
			exp_q.push_back(~modes[f]);
			for (int p = 0; p < `FRAME_PIXELS; p++) begin
				gap = (f == 0) ? int'(rand_bits(8)) : 0; // later frames stream nonstop
				if (gap > 0) begin
					pix_valid <= 1'b0;
					repeat (gap) @(posedge SYS_CLK);
				end
				send_pixel(rand_bits(`PIX_W));
			end
			exp_q.push_back(~modes[f]);
			exp_q.push_back(modes[f]);
		end
		pix_valid <= 1'b0;
		while (exp_q.size() != 0 || frame_active) @(posedge SYS_CLK);
		repeat (20 * `CLK_DIV) @(posedge SYS_CLK); // line must stay quiet
		assert (rx_cnt == N_FRAMES * FRAME_BYTES) else begin
			$display("** Error rx byte count: expected 0x%0h, got 0x%0h",
				N_FRAMES * FRAME_BYTES, rx_cnt);
			misc_errs++;
		end
		$display("errors: uart bytes %0d, other %0d, assertions %0d",
			byte_errs, misc_errs, i_dut.i_chk.fail_cnt);
		if (byte_errs + misc_errs + i_dut.i_chk.fail_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// serial decoder, samples mid bit between clock edges
	initial begin : rx_decode
		logic [7:0] rx_byte;
		wait (RST_N === 1'b1);
		forever begin
			@(negedge uart_txd); // start edge
			#(BIT_NS / 2 + 50);
			for (int i = 0; i < 8; i++) begin
				#(BIT_NS);
				rx_byte[i] = uart_txd; // lsb first
			end
			#(BIT_NS); // into stop bit
			check_byte(rx_byte);
		end
	end

	initial begin : watchdog
		repeat (2 * N_FRAMES * FRAME_CYCLES) @(posedge SYS_CLK);
		$display("timeout: %0d frames not sent within %0d cycles",
			N_FRAMES, 2 * N_FRAMES * FRAME_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
frame_pkg.sv
pixel_fifo.sv
uart_tx.sv
frame_ctrl.sv
frame_uart_top.sv
clk_gen.sv
frame_asserts.sv
tb_frame_uart.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_frame_uart
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) frame_defines.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
